/* verilog/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// data and address width
`define MEM_DW 32

// word address bits of the data ram, 256 words
`define MEM_RAM_AW 8

// bit positions in the exception vector
`define EXCP_ALE 0
`define EXCP_TLBR 1
`define EXCP_PIL 2
`define EXCP_PIS 3
`define EXCP_PPI 4
`define EXCP_PME 5

`endif

/* verilog/mem_op_pkg.sv */
`include "mem_macros.svh"

package mem_op_pkg;

    // operations handed over from execute
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL    = 4'd9,
        OP_SC    = 4'd10
    } mem_op_e;

    // one flag per memory exception, ale in bit 0 up to pme
    typedef logic [`EXCP_PME:0] excp_vec_t;

endpackage

/* verilog/csr_pkg.sv */
package csr_pkg;

    // register select on the config port
    typedef enum logic [1:0] {
        CSR_CRMD   = 2'd0,
        CSR_DMW0   = 2'd1,
        CSR_DMW1   = 2'd2,
        CSR_LLBCTL = 2'd3
    } csr_addr_e;

    // privilege level, 0 is kernel and 3 is user
    typedef logic [1:0] plv_t;

    // crmd fields
    localparam int unsigned CRMD_DA = 3;
    localparam int unsigned CRMD_PG = 4;

    // dmw fields, vseg is 3 bits wide
    localparam int unsigned DMW_PLV0 = 0;
    localparam int unsigned DMW_PLV3 = 3;
    localparam int unsigned DMW_VSEG = 29;

    // llbctl
    localparam int unsigned LLBCTL_LLB = 0;

endpackage

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_stage (
    input  logic                  rst_i,
    input  mem_op_pkg::mem_op_e   op_i,
    input  logic [`MEM_DW-1:0]    addr_i,
    input  logic [`MEM_DW-1:0]    wdata_i,
    input  logic                  tlb_found_i,
    input  logic                  tlb_v_i,
    input  logic                  tlb_d_i,
    input  csr_pkg::plv_t         tlb_plv_i,
    input  csr_pkg::plv_t         crmd_plv_i,
    input  logic                  crmd_da_i,
    input  logic                  crmd_pg_i,
    input  logic [`MEM_DW-1:0]    dmw0_i,
    input  logic [`MEM_DW-1:0]    dmw1_i,
    input  logic                  llbit_i,
    input  logic                  mem_busy_i,
    input  logic [`MEM_DW-1:0]    ram_rdata_i,
    output logic                  ram_ce_o,
    output logic                  ram_we_o,
    output logic [3:0]            ram_sel_o,
    output logic [`MEM_DW-1:0]    ram_addr_o,
    output logic [`MEM_DW-1:0]    ram_wdata_o,
    output logic                  llbit_we_o,
    output logic                  llbit_value_o,
    output logic [`MEM_DW-1:0]    rdata_o,
    output logic                  wreg_o,
    output logic                  excp_o,
    output mem_op_pkg::excp_vec_t excp_vec_o,
    output logic                  stallreq_o
);

    logic                  is_load;
    logic                  is_store;
    logic                  access;
    logic                  is_half;
    logic                  is_word;
    logic                  sign_ext;
    logic                  misaligned;
    logic                  trans_en;
    logic                  go;
    logic [7:0]            byte_data;
    logic [15:0]           half_data;
    logic [3:0]            byte_sel;
    logic [3:0]            half_sel;
    logic                  ce_raw;
    logic                  we_raw;
    logic                  wreg_raw;
    logic                  llbit_we_raw;
    logic [`MEM_DW-1:0]    rdata_raw;
    mem_op_pkg::excp_vec_t excp_vec;

    function automatic logic dmw_hit(
        input logic [`MEM_DW-1:0] dmw,
        input csr_pkg::plv_t      plv,
        input logic [2:0]         vseg
    );
        logic plv_ok;
        plv_ok = (dmw[csr_pkg::DMW_PLV0] && plv == 2'd0) ||
                 (dmw[csr_pkg::DMW_PLV3] && plv == 2'd3);
        return plv_ok && (dmw[csr_pkg::DMW_VSEG +: 3] == vseg);
    endfunction

    // nothing is requested while in reset
    assign is_load  = !rst_i && (op_i inside {mem_op_pkg::OP_LD_B, mem_op_pkg::OP_LD_BU,
        mem_op_pkg::OP_LD_H, mem_op_pkg::OP_LD_HU, mem_op_pkg::OP_LD_W, mem_op_pkg::OP_LL});
    assign is_store = !rst_i && (op_i inside {mem_op_pkg::OP_ST_B, mem_op_pkg::OP_ST_H,
        mem_op_pkg::OP_ST_W, mem_op_pkg::OP_SC});
    assign access   = is_load || is_store;

    assign is_half  = op_i inside {mem_op_pkg::OP_LD_H, mem_op_pkg::OP_LD_HU, mem_op_pkg::OP_ST_H};
    assign is_word  = op_i inside {mem_op_pkg::OP_LD_W, mem_op_pkg::OP_ST_W,
        mem_op_pkg::OP_LL, mem_op_pkg::OP_SC};
    assign sign_ext = op_i inside {mem_op_pkg::OP_LD_B, mem_op_pkg::OP_LD_H};

    assign misaligned = (is_half && addr_i[0]) || (is_word && addr_i[1:0] != 2'b00);

    // paging with no direct window hit
    assign trans_en = crmd_pg_i && !crmd_da_i &&
                      !dmw_hit(dmw0_i, crmd_plv_i, addr_i[31:29]) &&
                      !dmw_hit(dmw1_i, crmd_plv_i, addr_i[31:29]);

    always_comb begin
        excp_vec             = '0;
        excp_vec[`EXCP_ALE]  = access && misaligned;
        excp_vec[`EXCP_TLBR] = access && trans_en && !tlb_found_i;
        excp_vec[`EXCP_PIL]  = is_load && trans_en && !tlb_v_i;
        excp_vec[`EXCP_PIS]  = is_store && trans_en && !tlb_v_i;
        excp_vec[`EXCP_PPI]  = access && trans_en && (crmd_plv_i > tlb_plv_i);
        excp_vec[`EXCP_PME]  = is_store && trans_en && (crmd_plv_i <= tlb_plv_i) && !tlb_d_i;
    end

    assign excp_vec_o = excp_vec;
    assign excp_o     = |excp_vec;
    assign stallreq_o = access && mem_busy_i;
    assign go         = access && !excp_o;

    // big endian lanes, offset 0 is bits 31:24
    assign byte_data = ram_rdata_i[{~addr_i[1:0], 3'b000} +: 8];
    assign byte_sel  = 4'b1000 >> addr_i[1:0];
    assign half_data = addr_i[1] ? ram_rdata_i[15:0] : ram_rdata_i[31:16];
    assign half_sel  = addr_i[1] ? 4'b0011 : 4'b1100;

    always_comb begin
        ce_raw        = 1'b0;
        we_raw        = 1'b0;
        wreg_raw      = 1'b0;
        llbit_we_raw  = 1'b0;
        llbit_value_o = 1'b0;
        ram_sel_o     = 4'b0000;
        ram_wdata_o   = '0;
        rdata_raw     = '0;
        case (op_i)
            mem_op_pkg::OP_LD_B, mem_op_pkg::OP_LD_BU: begin
                ce_raw    = 1'b1;
                wreg_raw  = 1'b1;
                ram_sel_o = byte_sel;
                rdata_raw = {{24{byte_data[7] && sign_ext}}, byte_data};
            end
            mem_op_pkg::OP_LD_H, mem_op_pkg::OP_LD_HU: begin
                ce_raw    = 1'b1;
                wreg_raw  = 1'b1;
                ram_sel_o = half_sel;
                rdata_raw = {{16{half_data[15] && sign_ext}}, half_data};
            end
            mem_op_pkg::OP_LD_W: begin
                ce_raw    = 1'b1;
                wreg_raw  = 1'b1;
                ram_sel_o = 4'b1111;
                rdata_raw = ram_rdata_i;
            end
            mem_op_pkg::OP_LL: begin
                ce_raw        = 1'b1;
                ram_sel_o     = 4'b1111;
                rdata_raw     = ram_rdata_i;
                llbit_we_raw  = 1'b1;
                llbit_value_o = 1'b1;
            end
            mem_op_pkg::OP_ST_B: begin
                ce_raw      = 1'b1;
                we_raw      = 1'b1;
                ram_sel_o   = byte_sel;
                ram_wdata_o = {4{wdata_i[7:0]}};
            end
            mem_op_pkg::OP_ST_H: begin
                ce_raw      = 1'b1;
                we_raw      = 1'b1;
                ram_sel_o   = half_sel;
                ram_wdata_o = {2{wdata_i[15:0]}};
            end
            mem_op_pkg::OP_ST_W: begin
                ce_raw      = 1'b1;
                we_raw      = 1'b1;
                ram_sel_o   = 4'b1111;
                ram_wdata_o = wdata_i;
            end
            mem_op_pkg::OP_SC: begin
                // result register gets the success flag either way
                wreg_raw = 1'b1;
                if (llbit_i) begin
                    ce_raw       = 1'b1;
                    we_raw       = 1'b1;
                    ram_sel_o    = 4'b1111;
                    ram_wdata_o  = wdata_i;
                    llbit_we_raw = 1'b1;
                    rdata_raw    = `MEM_DW'(1);
                end
            end
            default: begin
                ce_raw = 1'b0;
            end
        endcase
    end

    assign ram_addr_o = addr_i;
    assign ram_ce_o   = go && ce_raw;
    assign ram_we_o   = go && we_raw && !stallreq_o;
    assign llbit_we_o = go && llbit_we_raw && !stallreq_o;
    assign wreg_o     = go && wreg_raw;
    assign rdata_o    = go ? rdata_raw : '0;

    // write strobe only with chip enable
    always_comb begin
        assert final (!ram_we_o || ram_ce_o)
            else $error("ram_we_o high without ram_ce_o");
    end

    // an excepting op leaves ram, ll bit and register file alone
    always_comb begin
        assert final (!excp_o || !(ram_ce_o || ram_we_o || llbit_we_o || wreg_o))
            else $error("side effect while excp_o is high");
    end

endmodule

/* verilog/mem_csr_regs.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_csr_regs (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                csr_we_i,
    input  csr_pkg::csr_addr_e  csr_addr_i,
    input  logic [`MEM_DW-1:0]  csr_wdata_i,
    input  logic                llbit_we_i,
    input  logic                llbit_value_i,
    output csr_pkg::plv_t       crmd_plv_o,
    output logic                crmd_da_o,
    output logic                crmd_pg_o,
    output logic [`MEM_DW-1:0]  dmw0_o,
    output logic [`MEM_DW-1:0]  dmw1_o,
    output logic                llbit_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            crmd_plv_o <= '0;
            crmd_da_o  <= 1'b0;
            crmd_pg_o  <= 1'b0;
            dmw0_o     <= '0;
            dmw1_o     <= '0;
            llbit_o    <= 1'b0;
        end else begin
            if (csr_we_i) begin
                case (csr_addr_i)
                    csr_pkg::CSR_CRMD: begin
                        crmd_plv_o <= csr_wdata_i[1:0];
                        crmd_da_o  <= csr_wdata_i[csr_pkg::CRMD_DA];
                        crmd_pg_o  <= csr_wdata_i[csr_pkg::CRMD_PG];
                    end
                    csr_pkg::CSR_DMW0: begin
                        dmw0_o <= csr_wdata_i;
                    end
                    csr_pkg::CSR_DMW1: begin
                        dmw1_o <= csr_wdata_i;
                    end
                    default: begin
                        llbit_o <= csr_wdata_i[csr_pkg::LLBCTL_LLB];
                    end
                endcase
            end
            // stage update comes last so it overrides llbctl
            if (llbit_we_i) begin
                llbit_o <= llbit_value_i;
            end
        end
    end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module data_ram (
    input  logic               clk,
    input  logic               ce_i,
    input  logic               we_i,
    input  logic [3:0]         sel_i,
    input  logic [`MEM_DW-1:0] addr_i,
    input  logic [`MEM_DW-1:0] wdata_i,
    input  logic               busy_i,
    output logic [`MEM_DW-1:0] rdata_o
);

    localparam int DEPTH = 1 << `MEM_RAM_AW;

    logic [`MEM_DW-1:0]     mem [DEPTH];
    logic [`MEM_RAM_AW-1:0] index;
    logic                   wr_en;

    // word index from byte address
    assign index   = addr_i[`MEM_RAM_AW+1:2];
    assign wr_en   = ce_i && we_i && !busy_i;
    assign rdata_o = ce_i ? mem[index] : '0;

    // sel bit 3 is the lane at offset 0
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_en && sel_i[i]) begin
                mem[index][i*8 +: 8] <= wdata_i[i*8 +: 8];
            end
        end
    end

    wr_sel_nonzero: assert property (@(posedge clk) wr_en |-> sel_i != 4'b0000)
        else $error("ram write with empty byte select");

endmodule

/* verilog/mem_top.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  mem_op_pkg::mem_op_e   op_i,
    input  logic [`MEM_DW-1:0]    addr_i,
    input  logic [`MEM_DW-1:0]    wdata_i,
    input  logic                  tlb_found_i,
    input  logic                  tlb_v_i,
    input  logic                  tlb_d_i,
    input  csr_pkg::plv_t         tlb_plv_i,
    input  logic                  mem_busy_i,
    input  logic                  csr_we_i,
    input  csr_pkg::csr_addr_e    csr_addr_i,
    input  logic [`MEM_DW-1:0]    csr_wdata_i,
    output logic [`MEM_DW-1:0]    rdata_o,
    output logic                  wreg_o,
    output logic                  excp_o,
    output mem_op_pkg::excp_vec_t excp_vec_o,
    output logic                  stallreq_o
);

    csr_pkg::plv_t      crmd_plv;
    logic               crmd_da;
    logic               crmd_pg;
    logic [`MEM_DW-1:0] dmw0;
    logic [`MEM_DW-1:0] dmw1;
    logic               llbit;
    logic               llbit_we;
    logic               llbit_value;
    logic               ram_ce;
    logic               ram_we;
    logic [3:0]         ram_sel;
    logic [`MEM_DW-1:0] ram_addr;
    logic [`MEM_DW-1:0] ram_wdata;
    logic [`MEM_DW-1:0] ram_rdata;

    mem_stage u_mem_stage (
        .rst_i         (rst_i),
        .op_i          (op_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .tlb_found_i   (tlb_found_i),
        .tlb_v_i       (tlb_v_i),
        .tlb_d_i       (tlb_d_i),
        .tlb_plv_i     (tlb_plv_i),
        .crmd_plv_i    (crmd_plv),
        .crmd_da_i     (crmd_da),
        .crmd_pg_i     (crmd_pg),
        .dmw0_i        (dmw0),
        .dmw1_i        (dmw1),
        .llbit_i       (llbit),
        .mem_busy_i    (mem_busy_i),
        .ram_rdata_i   (ram_rdata),
        .ram_ce_o      (ram_ce),
        .ram_we_o      (ram_we),
        .ram_sel_o     (ram_sel),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .llbit_we_o    (llbit_we),
        .llbit_value_o (llbit_value),
        .rdata_o       (rdata_o),
        .wreg_o        (wreg_o),
        .excp_o        (excp_o),
        .excp_vec_o    (excp_vec_o),
        .stallreq_o    (stallreq_o)
    );

    mem_csr_regs u_mem_csr_regs (
        .clk           (clk),
        .rst_i         (rst_i),
        .csr_we_i      (csr_we_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .llbit_we_i    (llbit_we),
        .llbit_value_i (llbit_value),
        .crmd_plv_o    (crmd_plv),
        .crmd_da_o     (crmd_da),
        .crmd_pg_o     (crmd_pg),
        .dmw0_o        (dmw0),
        .dmw1_o        (dmw1),
        .llbit_o       (llbit)
    );

    // stands in for the memory controller
    data_ram u_data_ram (
        .clk     (clk),
        .ce_i    (ram_ce),
        .we_i    (ram_we),
        .sel_i   (ram_sel),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .busy_i  (mem_busy_i),
        .rdata_o (ram_rdata)
    );

endmodule

/* bench/tb_mem_top.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_top;

    localparam int clk_period = 100;
    localparam int max_rows   = 96;

    localparam mem_op_pkg::excp_vec_t vec_none = '0;
    localparam mem_op_pkg::excp_vec_t vec_ale  = 6'(1 << `EXCP_ALE);
    localparam mem_op_pkg::excp_vec_t vec_tlbr = 6'(1 << `EXCP_TLBR);
    localparam mem_op_pkg::excp_vec_t vec_pil  = 6'(1 << `EXCP_PIL);
    localparam mem_op_pkg::excp_vec_t vec_pis  = 6'(1 << `EXCP_PIS);
    localparam mem_op_pkg::excp_vec_t vec_ppi  = 6'(1 << `EXCP_PPI);
    localparam mem_op_pkg::excp_vec_t vec_pme  = 6'(1 << `EXCP_PME);

    // one table row, either a config write or an operation
    typedef struct packed {
        logic                  cfg;
        csr_pkg::csr_addr_e    csr_addr;
        logic [31:0]           csr_wdata;
        mem_op_pkg::mem_op_e   op;
        logic [31:0]           addr;
        logic [31:0]           wdata;
        logic                  found;
        logic                  v;
        logic                  d;
        csr_pkg::plv_t         plv;
        logic                  busy;
        logic [31:0]           exp_rdata;
        logic                  exp_wreg;
        mem_op_pkg::excp_vec_t exp_vec;
        logic                  exp_stall;
    } row_t;

    logic                  clk;
    logic                  rst_i;
    mem_op_pkg::mem_op_e   op_i;
    logic [31:0]           addr_i;
    logic [31:0]           wdata_i;
    logic                  tlb_found_i;
    logic                  tlb_v_i;
    logic                  tlb_d_i;
    csr_pkg::plv_t         tlb_plv_i;
    logic                  mem_busy_i;
    logic                  csr_we_i;
    csr_pkg::csr_addr_e    csr_addr_i;
    logic [31:0]           csr_wdata_i;
    logic [31:0]           rdata_o;
    logic                  wreg_o;
    logic                  excp_o;
    mem_op_pkg::excp_vec_t excp_vec_o;
    logic                  stallreq_o;

    row_t          rows [max_rows];
    int            n_rows;
    int            n_checks;
    int            n_errors;
    int            cycle_count;
    int            timeout_limit;
    logic          cur_found;
    logic          cur_v;
    logic          cur_d;
    csr_pkg::plv_t cur_plv;

    mem_top dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .tlb_found_i (tlb_found_i),
        .tlb_v_i     (tlb_v_i),
        .tlb_d_i     (tlb_d_i),
        .tlb_plv_i   (tlb_plv_i),
        .mem_busy_i  (mem_busy_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .rdata_o     (rdata_o),
        .wreg_o      (wreg_o),
        .excp_o      (excp_o),
        .excp_vec_o  (excp_vec_o),
        .stallreq_o  (stallreq_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // tlb lookup result used by the rows added next
    task automatic set_tlb(input logic found, input logic v, input logic d,
                           input csr_pkg::plv_t plv);
        cur_found = found;
        cur_v     = v;
        cur_d     = d;
        cur_plv   = plv;
    endtask

    task automatic op_row(input mem_op_pkg::mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic busy,
                          input logic [31:0] exp_rdata, input logic exp_wreg,
                          input mem_op_pkg::excp_vec_t exp_vec, input logic exp_stall);
        row_t r;
        r.cfg       = 1'b0;
        r.csr_addr  = csr_pkg::CSR_CRMD;
        r.csr_wdata = '0;
        r.op        = op;
        r.addr      = addr;
        r.wdata     = wdata;
        r.found     = cur_found;
        r.v         = cur_v;
        r.d         = cur_d;
        r.plv       = cur_plv;
        r.busy      = busy;
        r.exp_rdata = exp_rdata;
        r.exp_wreg  = exp_wreg;
        r.exp_vec   = exp_vec;
        r.exp_stall = exp_stall;
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic cfg_row(input csr_pkg::csr_addr_e csr_addr, input logic [31:0] data);
        op_row(mem_op_pkg::OP_NOP, '0, '0, 1'b0, '0, 1'b0, vec_none, 1'b0);
        rows[n_rows-1].cfg       = 1'b1;
        rows[n_rows-1].csr_addr  = csr_addr;
        rows[n_rows-1].csr_wdata = data;
    endtask

    task automatic store_row(input mem_op_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
        op_row(op, addr, wdata, 1'b0, '0, 1'b0, vec_none, 1'b0);
    endtask

    task automatic load_row(input mem_op_pkg::mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] exp_rdata);
        op_row(op, addr, '0, 1'b0, exp_rdata, 1'b1, vec_none, 1'b0);
    endtask

    task automatic fault_row(input mem_op_pkg::mem_op_e op, input logic [31:0] addr,
                             input mem_op_pkg::excp_vec_t exp_vec);
        op_row(op, addr, 32'hffff_ffff, 1'b0, '0, 1'b0, exp_vec, 1'b0);
    endtask

    task automatic fill_table();
        set_tlb(1'b1, 1'b1, 1'b1, 2'd0);
        // word 0x40 goes 81 23 45 f6 from offset 0
        store_row(mem_op_pkg::OP_ST_W, 32'h40, 32'h8123_45f6);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h8123_45f6);
        load_row(mem_op_pkg::OP_LD_B, 32'h40, 32'hffff_ff81);
        load_row(mem_op_pkg::OP_LD_BU, 32'h40, 32'h0000_0081);
        load_row(mem_op_pkg::OP_LD_B, 32'h41, 32'h0000_0023);
        load_row(mem_op_pkg::OP_LD_BU, 32'h42, 32'h0000_0045);
        load_row(mem_op_pkg::OP_LD_B, 32'h43, 32'hffff_fff6);
        load_row(mem_op_pkg::OP_LD_BU, 32'h43, 32'h0000_00f6);
        load_row(mem_op_pkg::OP_LD_H, 32'h40, 32'hffff_8123);
        load_row(mem_op_pkg::OP_LD_HU, 32'h40, 32'h0000_8123);
        load_row(mem_op_pkg::OP_LD_H, 32'h42, 32'h0000_45f6);
        load_row(mem_op_pkg::OP_LD_HU, 32'h42, 32'h0000_45f6);
        store_row(mem_op_pkg::OP_ST_B, 32'h41, 32'h1234_56a7);
        load_row(mem_op_pkg::OP_LD_B, 32'h41, 32'hffff_ffa7);
        load_row(mem_op_pkg::OP_LD_BU, 32'h41, 32'h0000_00a7);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h81a7_45f6);
        store_row(mem_op_pkg::OP_ST_B, 32'h43, 32'hdead_be3c);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h81a7_453c);
        store_row(mem_op_pkg::OP_ST_H, 32'h42, 32'hcafe_9abc);
        load_row(mem_op_pkg::OP_LD_H, 32'h42, 32'hffff_9abc);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h81a7_9abc);
        store_row(mem_op_pkg::OP_ST_H, 32'h40, 32'h0000_7e11);
        load_row(mem_op_pkg::OP_LD_H, 32'h40, 32'h0000_7e11);
        load_row(mem_op_pkg::OP_LD_B, 32'h42, 32'hffff_ff9a);
        load_row(mem_op_pkg::OP_LD_BU, 32'h42, 32'h0000_009a);
        store_row(mem_op_pkg::OP_ST_B, 32'h40, 32'h0000_0055);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h5511_9abc);

        // ll and sc on word 0x80
        store_row(mem_op_pkg::OP_ST_W, 32'h80, 32'h1111_2222);
        op_row(mem_op_pkg::OP_SC, 32'h80, 32'h3333_4444, 1'b0, 32'd0, 1'b1, vec_none, 1'b0);
        load_row(mem_op_pkg::OP_LD_W, 32'h80, 32'h1111_2222);
        op_row(mem_op_pkg::OP_LL, 32'h80, '0, 1'b0, 32'h1111_2222, 1'b0, vec_none, 1'b0);
        op_row(mem_op_pkg::OP_SC, 32'h80, 32'h3333_4444, 1'b0, 32'd1, 1'b1, vec_none, 1'b0);
        load_row(mem_op_pkg::OP_LD_W, 32'h80, 32'h3333_4444);
        op_row(mem_op_pkg::OP_SC, 32'h80, 32'h5555_6666, 1'b0, 32'd0, 1'b1, vec_none, 1'b0);
        load_row(mem_op_pkg::OP_LD_W, 32'h80, 32'h3333_4444);

        // misaligned accesses raise ale alone
        fault_row(mem_op_pkg::OP_ST_H, 32'h41, vec_ale);
        fault_row(mem_op_pkg::OP_ST_W, 32'h42, vec_ale);
        fault_row(mem_op_pkg::OP_LD_H, 32'h41, vec_ale);
        fault_row(mem_op_pkg::OP_LD_W, 32'h42, vec_ale);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h5511_9abc);

        // paging on at plv0
        cfg_row(csr_pkg::CSR_CRMD, 32'h0000_0010);
        set_tlb(1'b0, 1'b1, 1'b1, 2'd0);
        fault_row(mem_op_pkg::OP_LD_W, 32'h40, vec_tlbr);
        set_tlb(1'b1, 1'b0, 1'b1, 2'd0);
        fault_row(mem_op_pkg::OP_LD_W, 32'h40, vec_pil);
        fault_row(mem_op_pkg::OP_ST_W, 32'h40, vec_pis);
        set_tlb(1'b1, 1'b1, 1'b0, 2'd0);
        fault_row(mem_op_pkg::OP_ST_W, 32'h40, vec_pme);
        set_tlb(1'b1, 1'b1, 1'b1, 2'd0);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h5511_9abc);
        // plv3 against a plv0 page
        cfg_row(csr_pkg::CSR_CRMD, 32'h0000_0013);
        fault_row(mem_op_pkg::OP_LD_W, 32'h40, vec_ppi);
        fault_row(mem_op_pkg::OP_ST_W, 32'h40, vec_ppi);

        // dmw0 maps segment 101 at plv0
        cfg_row(csr_pkg::CSR_CRMD, 32'h0000_0010);
        cfg_row(csr_pkg::CSR_DMW0, 32'ha000_0001);
        set_tlb(1'b0, 1'b0, 1'b0, 2'd0);
        store_row(mem_op_pkg::OP_ST_W, 32'ha000_0040, 32'h0bad_f00d);
        load_row(mem_op_pkg::OP_LD_W, 32'ha000_0040, 32'h0bad_f00d);
        fault_row(mem_op_pkg::OP_LD_W, 32'h40, vec_tlbr | vec_pil);
        cfg_row(csr_pkg::CSR_CRMD, 32'h0000_0000);
        set_tlb(1'b1, 1'b1, 1'b1, 2'd0);

        // busy memory holds the store back
        op_row(mem_op_pkg::OP_ST_W, 32'h40, 32'h1234_5678, 1'b1, '0, 1'b0, vec_none, 1'b1);
        load_row(mem_op_pkg::OP_LD_W, 32'h40, 32'h0bad_f00d);
        op_row(mem_op_pkg::OP_NOP, 32'h40, '0, 1'b1, '0, 1'b0, vec_none, 1'b0);
    endtask

    task automatic apply_row(input int i);
        @(posedge clk);
        csr_we_i    <= rows[i].cfg;
        csr_addr_i  <= rows[i].csr_addr;
        csr_wdata_i <= rows[i].csr_wdata;
        op_i        <= rows[i].op;
        addr_i      <= rows[i].addr;
        wdata_i     <= rows[i].wdata;
        tlb_found_i <= rows[i].found;
        tlb_v_i     <= rows[i].v;
        tlb_d_i     <= rows[i].d;
        tlb_plv_i   <= rows[i].plv;
        mem_busy_i  <= rows[i].busy;
    endtask

    task automatic check_reset_quiet();
        n_checks++;
        if (rdata_o !== 32'd0) begin
            $display("error: in reset rdata_o = 0x%h, expected 0x%h", rdata_o, 32'd0);
            n_errors++;
        end
        if (wreg_o !== 1'b0) begin
            $display("error: in reset wreg_o = 0x%h, expected 0x%h", wreg_o, 1'b0);
            n_errors++;
        end
        if (excp_o !== 1'b0) begin
            $display("error: in reset excp_o = 0x%h, expected 0x%h", excp_o, 1'b0);
            n_errors++;
        end
    endtask

    task automatic check_outputs(input int i);
        n_checks++;
        if (rdata_o !== rows[i].exp_rdata) begin
            $display("error: row %0d rdata_o = 0x%h, expected 0x%h", i, rdata_o,
                     rows[i].exp_rdata);
            n_errors++;
        end
        if (wreg_o !== rows[i].exp_wreg) begin
            $display("error: row %0d wreg_o = 0x%h, expected 0x%h", i, wreg_o,
                     rows[i].exp_wreg);
            n_errors++;
        end
        if (excp_vec_o !== rows[i].exp_vec) begin
            $display("error: row %0d excp_vec_o = 0x%h, expected 0x%h", i, excp_vec_o,
                     rows[i].exp_vec);
            n_errors++;
        end
        if (excp_o !== (|rows[i].exp_vec)) begin
            $display("error: row %0d excp_o = 0x%h, expected 0x%h", i, excp_o,
                     |rows[i].exp_vec);
            n_errors++;
        end
        if (stallreq_o !== rows[i].exp_stall) begin
            $display("error: row %0d stallreq_o = 0x%h, expected 0x%h", i, stallreq_o,
                     rows[i].exp_stall);
            n_errors++;
        end
    endtask

    initial begin
        cycle_count = 0;
        wait (timeout_limit != 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the table did not finish within %0d cycles", timeout_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        // a misaligned load during reset must stay silent
        rst_i       = 1'b1;
        op_i        = mem_op_pkg::OP_LD_W;
        addr_i      = 32'h42;
        wdata_i     = '0;
        tlb_found_i = 1'b1;
        tlb_v_i     = 1'b1;
        tlb_d_i     = 1'b1;
        tlb_plv_i   = 2'd0;
        mem_busy_i  = 1'b0;
        csr_we_i    = 1'b0;
        csr_addr_i  = csr_pkg::CSR_CRMD;
        csr_wdata_i = '0;
        n_rows      = 0;
        n_checks    = 0;
        n_errors    = 0;
        fill_table();
        timeout_limit = 4 * n_rows + 50;

        repeat (4) @(posedge clk);
        #(clk_period - 10);
        check_reset_quiet();
        // then an aligned one, which would otherwise write the register file
        @(posedge clk);
        addr_i <= 32'h40;
        repeat (4) @(posedge clk);
        #(clk_period - 10);
        check_reset_quiet();
        @(posedge clk);
        rst_i <= 1'b0;
        op_i  <= mem_op_pkg::OP_NOP;

        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
            #(clk_period - 10);
            check_outputs(i);
        end

        @(posedge clk);
        $display("rows checked: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/mem_op_pkg.sv
verilog/csr_pkg.sv
verilog/mem_stage.sv
verilog/mem_csr_regs.sv
verilog/data_ram.sv
verilog/mem_top.sv
bench/tb_mem_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mem_top -f flist.f \
    && ./obj_dir/Vtb_mem_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
